// ==== flist.f ====
design/cpuPkg.sv
design/stageIfs.sv
design/fetchStage.sv
design/regFile.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/cpuTop.sv
tests/cpuTop_props.sv
tests/cpuChecker.sv
tests/cpuTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cpuTop testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f flist.f \
  --top-module cpuTb \
  -Mdir obj_dir

./obj_dir/VcpuTb > sim.log 2>&1
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
exit 0

// ==== tests/cpuTb.sv ====
// testbench for cpuTop
// program is a short directed prologue followed by LFSR-generated words
// data memory returns address xor fillKey where nothing was written yet
// fetch past the program end sees opcode zero, which decodes as a no-op
`timescale 1ns/100ps
`default_nettype none

module cpuTb;
  import cpuPkg::*;

  localparam int progLen = 256;
  localparam int dirLen = 13;
  localparam int phaseLimit = 400;
  localparam wordT fillKey = 64'h5A3C_96E1_0F87_C3D2;
  // ALU opcodes, register forms first
  localparam logic [10:0] aluOps [0:9] = '{opAdd, opSub, opAnd, opOrr, opEor,
                                           opAddi, opSubi, opAndi, opOrri, opEori};

  logic        clk = 1'b0;
  logic        rstN;
  instrT       instr;
  wordT        iaddr;
  wordT        daddr;
  wordT        dataOut;
  wordT        dataIn;
  logic        dataWrEn;
  logic        dataRdEn;
  int          checks;
  int          errors;
  logic        timedOut;
  logic [31:0] lfsr;
  instrT       prog [0:progLen-1];
  wordT        dmem [wordT];

  always #20 clk = ~clk;

  cpuTop u_cpuTop (
    .clk     (clk),
    .rstN    (rstN),
    .instr   (instr),
    .iaddr   (iaddr),
    .daddr   (daddr),
    .dataOut (dataOut),
    .dataWrEn(dataWrEn),
    .dataRdEn(dataRdEn),
    .dataIn  (dataIn)
  );

  cpuChecker #(.fillKey(fillKey)) u_cpuChecker (
    .clk     (clk),
    .rstN    (rstN),
    .instr   (instr),
    .iaddr   (iaddr),
    .daddr   (daddr),
    .dataOut (dataOut),
    .dataWrEn(dataWrEn),
    .dataRdEn(dataRdEn),
    .checks  (checks),
    .errors  (errors)
  );

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrNext(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic drawBits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // R, I and D formats
  function automatic instrT encR(logic [10:0] op, regIdxT rm, regIdxT rn, regIdxT rd);
    return {op, rm, 6'd0, rn, rd};
  endfunction

  function automatic instrT encI(logic [10:0] op, logic [11:0] imm, regIdxT rn, regIdxT rd);
    return {op[10:1], imm, rn, rd};
  endfunction

  function automatic instrT encD(logic [10:0] op, logic [8:0] off, regIdxT rn, regIdxT rt);
    return {op, off, 2'b00, rn, rt};
  endfunction

  task automatic randomInstr(output instrT w);
    logic [31:0] sel;
    logic [31:0] rd;
    logic [31:0] rn;
    logic [31:0] rm;
    logic [31:0] imm;
    logic [31:0] low;
    logic [8:0]  off;
    drawBits(8, sel);
    if (sel < 32'd13) begin
      // about one in twenty, opcode zero matches nothing
      drawBits(21, low);
      w = {11'd0, low[20:0]};
    end else begin
      drawBits(5, rd);
      drawBits(5, rn);
      drawBits(5, rm);
      drawBits(12, imm);
      drawBits(4, sel);
      drawBits(1, low);
      off = imm[8:0];
      // X31 base with small aligned offsets so loads hit earlier stores
      if (low[0]) begin
        rn = 32'd31;
        off = {2'b00, imm[3:0], 3'b000};
      end
      if (sel < 32'd2) begin
        w = encD(opLdur, off, rn[4:0], rd[4:0]);
      end else if (sel < 32'd4 || sel > 32'd13) begin
        w = encD(opStur, off, rn[4:0], rd[4:0]);
      end else if (sel < 32'd9) begin
        w = encR(aluOps[sel - 32'd4], rm[4:0], rn[4:0], rd[4:0]);
      end else begin
        w = encI(aluOps[sel - 32'd4], imm[11:0], rn[4:0], rd[4:0]);
      end
    end
  endtask

  task automatic buildProgram();
    instrT w;
    // stores one, two and three slots after the write of X1
    prog[0]  = encI(opAddi, 12'hABC, zeroReg, 5'd1);
    prog[1]  = encD(opStur, 9'd0, zeroReg, 5'd1);
    prog[2]  = encD(opStur, 9'd8, zeroReg, 5'd1);
    prog[3]  = encD(opStur, 9'd16, zeroReg, 5'd1);
    // lost write to X31, then an unknown opcode
    prog[4]  = encI(opAddi, 12'h007, 5'd1, zeroReg);
    prog[5]  = 32'h0000_1234;
    prog[6]  = encR(opSub, 5'd1, zeroReg, 5'd2);
    // X31 as store data, negative offset
    prog[7]  = encD(opStur, 9'h1F8, 5'd1, zeroReg);
    prog[8]  = encD(opLdur, 9'd16, zeroReg, 5'd3);
    prog[9]  = encD(opLdur, 9'd40, zeroReg, 5'd4);
    prog[10] = encD(opStur, 9'd24, zeroReg, 5'd2);
    // loaded words stored three slots later
    prog[11] = encD(opStur, 9'd32, 5'd1, 5'd3);
    prog[12] = encD(opStur, 9'd48, zeroReg, 5'd4);
    for (int i = dirLen; i < progLen; i++) begin
      randomInstr(w);
      prog[i] = w;
    end
  endtask

  // instruction port, word index from iaddr
  always @(negedge clk) begin
    if (iaddr < wordT'(progLen * 4)) begin
      instr <= prog[iaddr[9:2]];
    end else begin
      instr <= '0;
    end
  end

  // data memory model
  always @(negedge clk) begin
    if (dmem.exists(daddr)) begin
      dataIn <= dmem[daddr];
    end else begin
      dataIn <= daddr ^ fillKey;
    end
  end

  always @(posedge clk) begin
    if (rstN && dataWrEn === 1'b1) begin
      dmem[daddr] = dataOut;
    end
  end

  // runs until iaddr reaches target, then reports this phase's counts
  task automatic runPhase(input string name, input wordT target);
    int startChecks;
    int startErrors;
    int waited;
    startChecks = checks;
    startErrors = errors;
    waited = 0;
    while (iaddr < target && waited < phaseLimit) begin
      @(negedge clk);
      waited++;
    end
    if (iaddr < target) begin
      $display("timeout: iaddr did not reach %h within %0d cycles", target, phaseLimit);
      timedOut = 1'b1;
    end
    $display("test %s: %0d checks, %0d errors", name, checks - startChecks,
             errors - startErrors);
  endtask

  initial begin
    rstN = 1'b0;
    instr = '0;
    dataIn = '0;
    timedOut = 1'b0;
    lfsr = 32'h7704041c;
    buildProgram();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    runPhase("reset and fetch start", 64'd16);
    if (!timedOut) begin
      runPhase("directed hazards", wordT'((dirLen + 5) * 4));
    end
    if (!timedOut) begin
      runPhase("random program", wordT'((progLen + 5) * 4));
    end
    $display("totals: %0d checks, %0d errors", checks, errors);
    if (timedOut || errors != 0) begin
      $display("Simulation FAILED");
    end else begin
      $display("Simulation PASSED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/cpuChecker.sv ====
// reference model and access comparison for cpuTop
// each fetched word runs in program order at the edge that fetches it
// reads see register writes from three or more slots earlier only
// predicted access is compared three rising edges after the fetch
`timescale 1ns/100ps
`default_nettype none

module cpuChecker #(
  parameter cpuPkg::wordT fillKey = '0
) (
  input  logic          clk,
  input  logic          rstN,
  input  cpuPkg::instrT instr,
  input  cpuPkg::wordT  iaddr,
  input  cpuPkg::wordT  daddr,
  input  cpuPkg::wordT  dataOut,
  input  logic          dataWrEn,
  input  logic          dataRdEn,
  output int            checks,
  output int            errors
);
  import cpuPkg::*;

  typedef struct packed {
    logic wr;
    logic rd;
    wordT addr;
    wordT data;
  } accessT;

  wordT   regs [0:31];
  wordT   mem [wordT];
  // writes of the last three slots, index 0 newest
  logic   pendEn [0:2];
  regIdxT pendIdx [0:2];
  wordT   pendData [0:2];
  accessT queued [$];
  wordT   expPc;

  initial begin
    checks = 0;
    errors = 0;
  end

  task automatic compareWord(input string name, input wordT got, input wordT exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, got %h", name, exp, got);
    end
  endtask

  function automatic wordT readReg(regIdxT i);
    return (i == 5'd31) ? '0 : regs[i];
  endfunction

  task automatic modelStep(input instrT w, output accessT acc);
    logic [10:0] op;
    regIdxT      rn;
    regIdxT      rm;
    regIdxT      rd;
    wordT        a;
    wordT        b;
    wordT        imm;
    wordT        off;
    wordT        res;
    logic        wrReg;
    op = w[31:21];
    rm = w[20:16];
    rn = w[9:5];
    rd = w[4:0];
    // write from three slots back lands before this read
    if (pendEn[2] && pendIdx[2] != 5'd31) begin
      regs[pendIdx[2]] = pendData[2];
    end
    pendEn[2] = pendEn[1];
    pendIdx[2] = pendIdx[1];
    pendData[2] = pendData[1];
    pendEn[1] = pendEn[0];
    pendIdx[1] = pendIdx[0];
    pendData[1] = pendData[0];
    a = readReg(rn);
    b = readReg(rm);
    imm = {52'd0, w[21:10]};
    off = {{55{w[20]}}, w[20:12]};
    acc = '0;
    res = '0;
    wrReg = 1'b1;
    if (op == opAdd) res = a + b;
    else if (op == opSub) res = a - b;
    else if (op == opAnd) res = a & b;
    else if (op == opOrr) res = a | b;
    else if (op == opEor) res = a ^ b;
    else if (op == opLdur) begin
      acc.rd = 1'b1;
      acc.addr = a + off;
      res = mem.exists(acc.addr) ? mem[acc.addr] : (acc.addr ^ fillKey);
    end else if (op == opStur) begin
      acc.wr = 1'b1;
      acc.addr = a + off;
      acc.data = readReg(rd);
      mem[acc.addr] = acc.data;
      wrReg = 1'b0;
    end
    // immediate forms ignore opcode bit 0
    else if (op[10:1] == opAddi[10:1]) res = a + imm;
    else if (op[10:1] == opSubi[10:1]) res = a - imm;
    else if (op[10:1] == opAndi[10:1]) res = a & imm;
    else if (op[10:1] == opOrri[10:1]) res = a | imm;
    else if (op[10:1] == opEori[10:1]) res = a ^ imm;
    else wrReg = 1'b0;
    pendEn[0] = wrReg;
    pendIdx[0] = rd;
    pendData[0] = res;
  endtask

  always @(posedge clk) begin
    accessT acc;
    accessT due;
    if (!rstN) begin
      expPc = '0;
      queued.delete();
      mem.delete();
      for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
      end
      for (int i = 0; i < 3; i++) begin
        pendEn[i] = 1'b0;
        pendIdx[i] = '0;
        pendData[i] = '0;
      end
    end else begin
      compareWord("iaddr", iaddr, expPc);
      expPc = expPc + 64'd4;
      // nothing due in the first three cycles
      due = '0;
      if (queued.size() == 3) begin
        due = queued.pop_front();
      end
      compareWord("dataWrEn", wordT'(dataWrEn), wordT'(due.wr));
      compareWord("dataRdEn", wordT'(dataRdEn), wordT'(due.rd));
      if (due.wr || due.rd) begin
        compareWord("daddr", daddr, due.addr);
      end
      if (due.wr) begin
        compareWord("dataOut", dataOut, due.data);
      end
      modelStep(instr, acc);
      queued.push_back(acc);
    end
  end

endmodule

`default_nettype wire

// ==== tests/cpuTop_props.sv ====
// concurrent checks bound into cpuTop
// strobes drop one edge into reset, are never both high, iaddr steps by pcStep
`timescale 1ns/100ps
`default_nettype none

module cpuTopProps (
  input logic         clk,
  input logic         rstN,
  input cpuPkg::wordT iaddr,
  input logic         dataWrEn,
  input logic         dataRdEn
);
  import cpuPkg::*;

  // valid flags clear on the first reset edge
  strobesLowInReset: assert property (@(posedge clk) !rstN |=> !dataWrEn && !dataRdEn)
    else $error("data strobe active after a reset edge");

  oneStrobeOnly: assert property (@(posedge clk) disable iff (!rstN)
    !(dataWrEn && dataRdEn))
    else $error("dataWrEn and dataRdEn high together");

  // no branches, so every cycle steps
  pcSteps: assert property (@(posedge clk) rstN && $past(rstN) |->
    iaddr == $past(iaddr) + wordT'(pcStep))
    else $error("iaddr did not step by 4");

endmodule

bind cpuTop cpuTopProps u_cpuTopProps (
  .clk     (clk),
  .rstN    (rstN),
  .iaddr   (iaddr),
  .dataWrEn(dataWrEn),
  .dataRdEn(dataRdEn)
);

`default_nettype wire

// ==== design/cpuTop.sv ====
// five-stage 64-bit core for a LEGv8 subset
// no hazard detection, no forwarding, no branches
// separate data read and write ports, strobes mark the access cycle
// fetch never stalls, instr must be valid every cycle
`timescale 1ns/100ps
`default_nettype none

module cpuTop (
  input  logic          clk,
  input  logic          rstN,
  input  cpuPkg::instrT instr,
  output cpuPkg::wordT  iaddr,
  output cpuPkg::wordT  daddr,
  output cpuPkg::wordT  dataOut,
  output logic          dataWrEn,
  output logic          dataRdEn,
  input  cpuPkg::wordT  dataIn
);
  import cpuPkg::*;

  instrT  fetchedInstr;
  logic   fetchedValid;
  // writeback path into the register file
  logic   wbEn;
  regIdxT wbIdx;
  wordT   wbData;

  idExBus  idEx ();
  exMemBus exMem ();

  fetchStage u_fetchStage (
    .clk         (clk),
    .rstN        (rstN),
    .instr       (instr),
    .iaddr       (iaddr),
    .fetchedInstr(fetchedInstr),
    .fetchedValid(fetchedValid)
  );

  decodeStage u_decodeStage (
    .clk         (clk),
    .rstN        (rstN),
    .fetchedInstr(fetchedInstr),
    .fetchedValid(fetchedValid),
    .wbEn        (wbEn),
    .wbIdx       (wbIdx),
    .wbData      (wbData),
    .idEx        (idEx.src)
  );

  executeStage u_executeStage (
    .clk  (clk),
    .rstN (rstN),
    .idEx (idEx.dst),
    .exMem(exMem.src)
  );

  memoryStage u_memoryStage (
    .clk     (clk),
    .rstN    (rstN),
    .exMem   (exMem.dst),
    .daddr   (daddr),
    .dataOut (dataOut),
    .dataWrEn(dataWrEn),
    .dataRdEn(dataRdEn),
    .dataIn  (dataIn),
    .wbEn    (wbEn),
    .wbIdx   (wbIdx),
    .wbData  (wbData)
  );

endmodule

`default_nettype wire

// ==== design/memoryStage.sv ====
// data port drive and MEM/WB register
// daddr, dataOut and the strobes are combinational from EX/MEM
// dataIn is sampled at the end of the load's memory cycle
// writeback outputs come straight from MEM/WB
`timescale 1ns/100ps
`default_nettype none

module memoryStage (
  input  logic           clk,
  input  logic           rstN,
  exMemBus.dst           exMem,
  output cpuPkg::wordT   daddr,
  output cpuPkg::wordT   dataOut,
  output logic           dataWrEn,
  output logic           dataRdEn,
  input  cpuPkg::wordT   dataIn,
  output logic           wbEn,
  output cpuPkg::regIdxT wbIdx,
  output cpuPkg::wordT   wbData
);
  import cpuPkg::*;

  // address is the ALU result
  assign daddr    = exMem.result;
  assign dataOut  = exMem.storeData;
  // strobes only for real instructions
  assign dataWrEn = exMem.valid && exMem.isStore;
  assign dataRdEn = exMem.valid && exMem.isLoad;

  // stores write no register
  always_ff @(posedge clk) begin
    if (!rstN) begin
      wbEn <= 1'b0;
    end else begin
      wbEn <= exMem.valid && !exMem.isStore;
    end
  end

  // loaded word or ALU result
  always_ff @(posedge clk) begin
    wbIdx  <= exMem.rd;
    wbData <= exMem.isLoad ? dataIn : exMem.result;
  end

endmodule

`default_nettype wire

// ==== design/executeStage.sv ====
// operand select, ALU and EX/MEM register
// loads and stores always add imm to the base register
// add and sub share a single adder
`timescale 1ns/100ps
`default_nettype none

module executeStage (
  input  logic clk,
  input  logic rstN,
  idExBus.dst  idEx,
  exMemBus.src exMem
);
  import cpuPkg::*;

  logic  isMem;
  logic  doSub;
  wordT  opSel;
  wordT  addIn;
  wordT  sum;
  wordT  aluOut;
  aluOpE op;

  assign isMem = idEx.isLoad || idEx.isStore;

  // memory ops force the offset and an add
  assign opSel = (idEx.useImm || isMem) ? idEx.imm : idEx.opB;
  assign op    = isMem ? aluAdd : idEx.aluOp;

  // subtract as a + ~b + 1
  assign doSub = (op == aluSub);
  assign addIn = doSub ? ~opSel : opSel;
  assign sum   = idEx.opA + addIn + wordT'(doSub);

  always_comb begin
    case (op)
      aluAnd: aluOut = idEx.opA & opSel;
      aluOrr: aluOut = idEx.opA | opSel;
      aluEor: aluOut = idEx.opA ^ opSel;
      default: aluOut = sum;
    endcase
  end

  // EX/MEM control
  always_ff @(posedge clk) begin
    if (!rstN) begin
      exMem.valid   <= 1'b0;
      exMem.isLoad  <= 1'b0;
      exMem.isStore <= 1'b0;
    end else begin
      exMem.valid   <= idEx.valid;
      exMem.isLoad  <= idEx.isLoad;
      exMem.isStore <= idEx.isStore;
    end
  end

  // EX/MEM payload, store data is the raw opB
  always_ff @(posedge clk) begin
    exMem.result    <= aluOut;
    exMem.storeData <= idEx.opB;
    exMem.rd        <= idEx.rd;
  end

endmodule

`default_nettype wire

// ==== design/decodeStage.sv ====
// opcode decode, operand read and ID/EX register
// no hazard detection and no forwarding
// an instruction sees writes from three or more slots earlier only
// unknown opcodes drop valid and so act as no-ops
`timescale 1ns/100ps
`default_nettype none

module decodeStage (
  input  logic           clk,
  input  logic           rstN,
  input  cpuPkg::instrT  fetchedInstr,
  input  logic           fetchedValid,
  input  logic           wbEn,
  input  cpuPkg::regIdxT wbIdx,
  input  cpuPkg::wordT   wbData,
  idExBus.src            idEx
);
  import cpuPkg::*;

  logic [10:0] opcode;
  regIdxT      rnIdx;
  regIdxT      rmIdx;
  regIdxT      rdIdx;
  regIdxT      rdIdxB;
  wordT        rdDataA;
  wordT        rdDataB;
  wordT        immVal;
  aluOpE       aluOp;
  logic        useImm;
  logic        isLoad;
  logic        isStore;
  logic        known;

  assign opcode = opcodeOf(fetchedInstr);
  assign rnIdx  = rnOf(fetchedInstr);
  assign rmIdx  = rmOf(fetchedInstr);
  assign rdIdx  = rdOf(fetchedInstr);

  always_comb begin
    known   = 1'b1;
    aluOp   = aluAdd;
    useImm  = 1'b0;
    isLoad  = 1'b0;
    isStore = 1'b0;
    case (opcode)
      opAdd: aluOp = aluAdd;
      opSub: aluOp = aluSub;
      opAnd: aluOp = aluAnd;
      opOrr: aluOp = aluOrr;
      opEor: aluOp = aluEor;
      // address is base plus offset, always an add
      opLdur: isLoad = 1'b1;
      opStur: isStore = 1'b1;
      default: begin
        // immediate forms match on the upper ten bits
        useImm = 1'b1;
        case (opcode[10:1])
          opAddi[10:1]: aluOp = aluAdd;
          opSubi[10:1]: aluOp = aluSub;
          opAndi[10:1]: aluOp = aluAnd;
          opOrri[10:1]: aluOp = aluOrr;
          opEori[10:1]: aluOp = aluEor;
          default: known = 1'b0;
        endcase
      end
    endcase
  end

  // offset for data transfer, zero-extended imm12 otherwise
  assign immVal = (isLoad || isStore) ? offsetOf(fetchedInstr) : aluImmOf(fetchedInstr);

  // store data comes from the rd field
  assign rdIdxB = isStore ? rdIdx : rmIdx;

  regFile u_regFile (
    .clk    (clk),
    .rstN   (rstN),
    .rdIdxA (rnIdx),
    .rdIdxB (rdIdxB),
    .rdDataA(rdDataA),
    .rdDataB(rdDataB),
    .wrEn   (wbEn),
    .wrIdx  (wbIdx),
    .wrData (wbData)
  );

  // ID/EX control
  always_ff @(posedge clk) begin
    if (!rstN) begin
      idEx.valid   <= 1'b0;
      idEx.isLoad  <= 1'b0;
      idEx.isStore <= 1'b0;
    end else begin
      idEx.valid   <= fetchedValid && known;
      idEx.isLoad  <= isLoad;
      idEx.isStore <= isStore;
    end
  end

  // ID/EX payload
  always_ff @(posedge clk) begin
    idEx.aluOp  <= aluOp;
    idEx.opA    <= rdDataA;
    idEx.opB    <= rdDataB;
    idEx.imm    <= immVal;
    idEx.useImm <= useImm;
    idEx.rd     <= rdIdx;
  end

endmodule

`default_nettype wire

// ==== design/regFile.sv ====
// 31 x 64-bit register file, index 31 reads zero and ignores writes
// writes on the rising edge
// a same-cycle read of the written index returns the new data
`timescale 1ns/100ps
`default_nettype none

module regFile (
  input  logic           clk,
  input  logic           rstN,
  input  cpuPkg::regIdxT rdIdxA,
  input  cpuPkg::regIdxT rdIdxB,
  output cpuPkg::wordT   rdDataA,
  output cpuPkg::wordT   rdDataB,
  input  logic           wrEn,
  input  cpuPkg::regIdxT wrIdx,
  input  cpuPkg::wordT   wrData
);
  import cpuPkg::*;

  wordT regs [0:30];
  logic wrLive;

  // writes to the zero register never land
  assign wrLive = wrEn && (wrIdx != zeroReg);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < 31; i++) begin
        regs[i] <= '0;
      end
    end else if (wrLive) begin
      regs[wrIdx] <= wrData;
    end
  end

  // zero reg first, then bypass, then array
  always_comb begin
    if (rdIdxA == zeroReg) begin
      rdDataA = '0;
    end else if (wrLive && (wrIdx == rdIdxA)) begin
      rdDataA = wrData;
    end else begin
      rdDataA = regs[rdIdxA];
    end
  end

  always_comb begin
    if (rdIdxB == zeroReg) begin
      rdDataB = '0;
    end else if (wrLive && (wrIdx == rdIdxB)) begin
      rdDataB = wrData;
    end else begin
      rdDataB = regs[rdIdxB];
    end
  end

endmodule

`default_nettype wire

// ==== design/fetchStage.sv ====
// program counter and IF/ID register
// no branches, so the PC steps by pcStep every cycle
// iaddr is the PC itself, the instruction is sampled at the end of the cycle
`timescale 1ns/100ps
`default_nettype none

module fetchStage (
  input  logic          clk,
  input  logic          rstN,
  input  cpuPkg::instrT instr,
  output cpuPkg::wordT  iaddr,
  output cpuPkg::instrT fetchedInstr,
  output logic          fetchedValid
);
  import cpuPkg::*;

  wordT pc;

  // starts at zero, no stall
  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= '0;
    end else begin
      pc <= pc + wordT'(pcStep);
    end
  end

  assign iaddr = pc;

  // IF/ID instruction word
  always_ff @(posedge clk) begin
    fetchedInstr <= instr;
  end

  // first valid word is the one fetched at address 0
  always_ff @(posedge clk) begin
    if (!rstN) begin
      fetchedValid <= 1'b0;
    end else begin
      fetchedValid <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== design/stageIfs.sv ====
// inter-stage buses of the pipeline, no handshake
// valid is a level marking a real instruction in the stage
// src side is the registered output of the earlier stage
`timescale 1ns/100ps
`default_nettype none

interface idExBus;
  import cpuPkg::*;

  logic   valid;
  aluOpE  aluOp;
  // register values, opB carries store data for STUR
  wordT   opA;
  wordT   opB;
  // extended immediate or data offset
  wordT   imm;
  logic   useImm;
  logic   isLoad;
  logic   isStore;
  regIdxT rd;

  modport src (
    output valid, aluOp, opA, opB, imm, useImm, isLoad, isStore, rd
  );

  modport dst (
    input valid, aluOp, opA, opB, imm, useImm, isLoad, isStore, rd
  );
endinterface

interface exMemBus;
  import cpuPkg::*;

  logic   valid;
  // ALU result, or the address for loads and stores
  wordT   result;
  wordT   storeData;
  regIdxT rd;
  logic   isLoad;
  logic   isStore;

  modport src (
    output valid, result, storeData, rd, isLoad, isStore
  );

  modport dst (
    input valid, result, storeData, rd, isLoad, isStore
  );
endinterface

`default_nettype wire

// ==== design/cpuPkg.sv ====
// widths, opcodes, ALU operation codes and instruction field helpers
// opcodes follow the LEGv8 encodings, immediate forms ignore opcode bit 0
// ALU immediates are zero-extended, data offsets are sign-extended
`default_nettype none

package cpuPkg;

  localparam int xlen    = 64;
  localparam int instrW  = 32;
  localparam int regIdxW = 5;
  localparam int pcStep  = 4;

  typedef logic [xlen-1:0]    wordT;
  typedef logic [regIdxW-1:0] regIdxT;
  typedef logic [instrW-1:0]  instrT;

  // reads as zero, writes dropped
  localparam regIdxT zeroReg = 5'd31;

  // register-register forms
  localparam logic [10:0] opAdd  = 11'b10001011000;
  localparam logic [10:0] opSub  = 11'b11001011000;
  localparam logic [10:0] opAnd  = 11'b10001010000;
  localparam logic [10:0] opOrr  = 11'b10101010000;
  localparam logic [10:0] opEor  = 11'b11001010000;
  // immediate forms, bit 0 is don't care
  localparam logic [10:0] opAddi = 11'b10010001000;
  localparam logic [10:0] opSubi = 11'b11010001000;
  localparam logic [10:0] opAndi = 11'b10010010000;
  localparam logic [10:0] opOrri = 11'b10110010000;
  localparam logic [10:0] opEori = 11'b11010010000;
  // data transfer
  localparam logic [10:0] opLdur = 11'b11111000010;
  localparam logic [10:0] opStur = 11'b11111000000;

  typedef enum logic [2:0] {
    aluAdd = 3'd0,
    aluSub = 3'd1,
    aluAnd = 3'd2,
    aluOrr = 3'd3,
    aluEor = 3'd4
  } aluOpE;

  // field extraction
  function automatic logic [10:0] opcodeOf(instrT i);
    return i[31:21];
  endfunction

  function automatic regIdxT rmOf(instrT i);
    return i[20:16];
  endfunction

  function automatic regIdxT rnOf(instrT i);
    return i[9:5];
  endfunction

  function automatic regIdxT rdOf(instrT i);
    return i[4:0];
  endfunction

  // 12-bit ALU immediate, zero-extended
  function automatic wordT aluImmOf(instrT i);
    return {{(xlen-12){1'b0}}, i[21:10]};
  endfunction

  // 9-bit data offset, sign-extended
  function automatic wordT offsetOf(instrT i);
    return {{(xlen-9){i[20]}}, i[20:12]};
  endfunction

endpackage

`default_nettype wire
